//--- project.f
+incdir+verilog
verilog/spiCtrlPkg.sv
verilog/spiClockDivider.sv
verilog/spiShifter.sv
verilog/spiBurstQueue.sv
verilog/spiMmioPort.sv
verilog/spiController.sv
verification/spiClockGen.sv
verification/spiController_assert.sv
verification/spiControllerTb.sv

//--- run.sh
#!/bin/sh
# build and run the spi controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module spiControllerTb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/VspiControllerTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

//--- verification/spiClockGen.sv
// testbench clock and reset source
// free running clock, reset held high for the first cycles
`timescale 1ns/10ps
`default_nettype none

module spiClockGen
#(
	parameter int PeriodNs    = 8,
	parameter int ResetCycles = 5
)
(
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever
			#(PeriodNs / 2) clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clock);
		// released on a falling edge like every other input
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- verification/spiControllerTb.sv
// spi controller testbench
// bus tasks, spi slave model, reference model, byte checker and watchdog
`timescale 1ns/10ps
`default_nettype none
`include "spiCtrl_consts.svh"

module spiControllerTb;

	localparam int MaxHalf     = 12;
	localparam int AccessLimit = 20000;
	// four long bursts at the slowest half period, plus margin
	localparam int WatchdogNs  = 4 * 32 * 8 * 2 * MaxHalf * 8 + 20000;
	localparam logic [31:0] CtrlAddr  = `SPI_BASE_ADDR + `SPI_REG_CTRL;
	localparam logic [31:0] DataAddr  = `SPI_BASE_ADDR + `SPI_REG_DATA;
	localparam logic [31:0] QueueAddr = `SPI_BASE_ADDR + `SPI_REG_QUEUE;

	logic clock;
	logic reset;
	spiCtrlPkg::mmioReq_t req;
	spiCtrlPkg::mmioOk_t  ok;
	logic [63:0] readData;
	spiCtrlPkg::spiPins_t pins;
	logic [3:0]  miso;

	int errors = 0;
	int passCount = 0;
	int failCount = 0;
	logic [7:0] expQ [$];
	logic [7:0] seenQ [$];
	// slave model state
	logic slavePol = 1'b0;
	logic prevAct;
	logic [7:0] shiftIn;
	int byteIdx;
	int bitPos;
	int leadLen;
	int lastLead;

	spiClockGen #(.PeriodNs(8), .ResetCycles(5)) clockGen (.clock(clock), .reset(reset));

	spiController dut
	(
		.clock(clock), .reset(reset), .req(req), .ok(ok),
		.readData(readData), .pins(pins), .miso(miso)
	);

	initial
	begin
		req  = '0;
		miso = 4'h0;
	end

	// slave response rule: byte index times 0x11, xor 0x3C
	function automatic logic [7:0] respByte(input int idx);
		logic [7:0] t;
		t = idx[7:0] * 8'h11;
		return t ^ 8'h3C;
	endfunction

	// receive word k holds response bytes 8k to 8k+7, low byte first
	function automatic logic [63:0] expectRecv(input int word);
		logic [63:0] w;
		for (int b = 0; b < 8; b++)
			w[8*b +: 8] = respByte(word * 8 + b);
		return w;
	endfunction

	// byte k of the send stream, word 0 low byte first
	function automatic logic [7:0] sentByte(input logic [255:0] chain, input int k);
		return chain[8*k +: 8];
	endfunction

	function automatic logic [31:0] makeCtrl(input logic [7:0] div, input logic [1:0] scale,
		input logic pol, input logic quad, input logic cs, input logic [2:0] start);
		spiCtrlPkg::spiCtrl_t c;
		c = '0;
		c.divisor    = div;
		c.scale      = scale;
		c.polarity   = pol;
		c.laneQuad   = quad;
		c.chipSelect = cs;
		c.single     = start[0];
		c.burst8     = start[1];
		c.burst32    = start[2];
		return c;
	endfunction

	// slave: miso set when the leading half starts, mosi taken when it ends
	always @(negedge clock)
	begin
		logic act;
		logic [7:0] resp;
		act  = pins.cs && (pins.sclk != slavePol);
		resp = respByte(byteIdx);
		if (reset || !pins.cs)
		begin
			byteIdx = 0;
			bitPos  = 0;
		end
		else if (act && !prevAct)
		begin
			leadLen = 1;
			if (pins.laneMode[1])
				miso = (bitPos == 0) ? resp[7:4] : resp[3:0];
			else
				miso = {3'b000, resp[7 - bitPos]};
		end
		else if (act)
			leadLen++;
		else if (prevAct)
		begin
			lastLead = leadLen;
			shiftIn = pins.laneMode[1] ? {shiftIn[3:0], pins.mosi} : {shiftIn[6:0], pins.mosi[0]};
			bitPos++;
			if (bitPos == (pins.laneMode[1] ? 2 : 8))
			begin
				seenQ.push_back(shiftIn);
				byteIdx++;
				bitPos = 0;
			end
		end
		prevAct = act;
	end

	// byte checker against the reference stream
	always @(negedge clock)
	begin
		logic [7:0] e;
		logic [7:0] g;
		if (expQ.size() > 0 && seenQ.size() > 0)
		begin
			e = expQ.pop_front();
			g = seenQ.pop_front();
			if (g !== e)
			begin
				$display("ERROR @%0t: slave saw byte %02h, expected %02h", $time, g, e);
				errors++;
			end
		end
	end

	// level request held until OK, answer two edges later
	task automatic busAccess(input spiCtrlPkg::mmioOp_t op, input logic [31:0] addr,
		input logic [63:0] data, output logic [63:0] rdata, output int holds);
		int waited;
		holds  = 0;
		waited = 0;
		@(negedge clock);
		req.op   = op;
		req.addr = addr;
		req.data = data;
		repeat (2) @(negedge clock);
		while (ok != spiCtrlPkg::MMIO_OK && waited < AccessLimit)
		begin
			if (ok == spiCtrlPkg::MMIO_HOLD)
				holds++;
			@(negedge clock);
			waited++;
		end
		rdata = readData;
		if (ok != spiCtrlPkg::MMIO_OK)
		begin
			$display("access to %08h never answered OK", addr);
			errors++;
		end
		req.op = spiCtrlPkg::MMIO_IDLE;
		// stale answer drains
		repeat (2) @(negedge clock);
	endtask

	task automatic writeReg(input logic [31:0] addr, input logic [63:0] data, output int holds);
		logic [63:0] unused;
		busAccess(spiCtrlPkg::MMIO_WRITE, addr, data, unused, holds);
	endtask

	task automatic readReg(input logic [31:0] addr, output logic [63:0] rdata);
		int holds;
		busAccess(spiCtrlPkg::MMIO_READ, addr, 64'h0, rdata, holds);
	endtask

	task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERROR @%0t: %s is %016h, expected %016h", $time, what, got, exp);
			errors++;
		end
	endtask

	// cs dropped and raised so the slave counts from byte 0
	task automatic selectSlave(input logic [7:0] div, input logic [1:0] scale,
		input logic pol, input logic quad);
		int holds;
		slavePol = pol;
		writeReg(CtrlAddr, {32'h0, makeCtrl(div, scale, pol, quad, 1'b0, 3'b000)}, holds);
		writeReg(CtrlAddr, {32'h0, makeCtrl(div, scale, pol, quad, 1'b1, 3'b000)}, holds);
		seenQ.delete();
		expQ.delete();
	endtask

	task automatic waitIdle();
		logic [63:0] r;
		int n;
		n = 0;
		r = 64'h2;
		while (r[1] && n < 2000)
		begin
			readReg(CtrlAddr, r);
			n++;
		end
		if (r[1])
		begin
			$display("controller stayed busy after the burst");
			errors++;
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		repeat (2) @(negedge clock);
		if (expQ.size() != 0)
		begin
			$display("slave missed %0d expected bytes", expQ.size());
			errors++;
			expQ.delete();
		end
		if (errors == errBefore)
		begin
			passCount++;
			$display("test %s: passed", name);
		end
		else
		begin
			failCount++;
			$display("test %s: failed", name);
		end
	endtask

	initial
	begin
		#(WatchdogNs);
		$display("watchdog expired after %0d ns, run did not finish", WatchdogNs);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		logic [63:0] r;
		logic [255:0] chain;
		logic [31:0] value;
		logic [7:0] tx;
		int holds;
		int e0;
		void'($urandom(58060));
		@(negedge reset);
		repeat (2) @(negedge clock);

		// single byte, single lane
		e0 = errors;
		tx = $urandom;
		selectSlave(8'd2, 2'd0, 1'b0, 1'b0);
		writeReg(DataAddr, {56'h0, tx}, holds);
		expQ.push_back(tx);
		writeReg(CtrlAddr, {32'h0, makeCtrl(8'd2, 2'd0, 1'b0, 1'b0, 1'b1, 3'b001)}, holds);
		readReg(DataAddr, r);
		checkValue("data read", r, {56'h0, respByte(0)});
		finishTest("single byte", e0);

		// 8-byte burst from send word 0
		e0 = errors;
		chain = {192'h0, $urandom, $urandom};
		selectSlave(8'd2, 2'd0, 1'b0, 1'b0);
		writeReg(QueueAddr, chain[63:0], holds);
		for (int k = 0; k < 8; k++)
			expQ.push_back(sentByte(chain, k));
		writeReg(CtrlAddr, {32'h0, makeCtrl(8'd2, 2'd0, 1'b0, 1'b0, 1'b1, 3'b010)}, holds);
		waitIdle();
		readReg(QueueAddr, r);
		checkValue("receive word 0", r, expectRecv(0));
		finishTest("burst 8", e0);

		// 32-byte burst, quad lanes
		e0 = errors;
		for (int w = 0; w < 4; w++)
			chain[64*w +: 64] = {$urandom, $urandom};
		selectSlave(8'd2, 2'd0, 1'b0, 1'b1);
		for (int w = 0; w < 4; w++)
			writeReg(QueueAddr + 8 * w, chain[64*w +: 64], holds);
		for (int k = 0; k < 32; k++)
			expQ.push_back(sentByte(chain, k));
		writeReg(CtrlAddr, {32'h0, makeCtrl(8'd2, 2'd0, 1'b0, 1'b1, 1'b1, 3'b100)}, holds);
		waitIdle();
		for (int w = 0; w < 4; w++)
		begin
			readReg(QueueAddr + 8 * w, r);
			checkValue("receive word", r, expectRecv(w));
		end
		checkValue("lane mode", {62'h0, pins.laneMode}, 64'h2);
		finishTest("burst 32 quad", e0);

		// control write held behind a running burst
		e0 = errors;
		selectSlave(8'd2, 2'd0, 1'b0, 1'b0);
		writeReg(CtrlAddr, {32'h0, makeCtrl(8'd2, 2'd0, 1'b0, 1'b0, 1'b1, 3'b010)}, holds);
		value = makeCtrl(8'd3, 2'd0, 1'b0, 1'b0, 1'b1, 3'b000);
		writeReg(CtrlAddr, {32'h0, value}, holds);
		if (holds == 0)
		begin
			$display("ERROR @%0t: control write during burst was never held", $time);
			errors++;
		end
		readReg(CtrlAddr, r);
		checkValue("control after hold", r, {32'h0, value});
		seenQ.delete();
		finishTest("held control write", e0);

		// polarity 1, scale 1, half period divisor times 4
		e0 = errors;
		tx = $urandom;
		selectSlave(8'd3, 2'd1, 1'b1, 1'b0);
		checkValue("idle sclk before", {63'h0, pins.sclk}, 64'h1);
		writeReg(DataAddr, {56'h0, tx}, holds);
		expQ.push_back(tx);
		writeReg(CtrlAddr, {32'h0, makeCtrl(8'd3, 2'd1, 1'b1, 1'b0, 1'b1, 3'b001)}, holds);
		readReg(DataAddr, r);
		checkValue("data read", r, {56'h0, respByte(0)});
		checkValue("half period", lastLead, 3 * 4);
		checkValue("idle sclk after", {63'h0, pins.sclk}, 64'h1);
		finishTest("polarity and scale", e0);

		// access outside the block window
		e0 = errors;
		// last control write minus its single start bit
		value = makeCtrl(8'd3, 2'd1, 1'b1, 1'b0, 1'b1, 3'b000);
		readReg(CtrlAddr, r);
		checkValue("control before miss", r, {32'h0, value});
		@(negedge clock);
		req.op   = spiCtrlPkg::MMIO_WRITE;
		req.addr = CtrlAddr ^ 32'h0000_1000;
		req.data = 64'hFFFF_FFFF_FFFF_FFFF;
		repeat (4)
		begin
			@(negedge clock);
			checkValue("answer outside block", {62'h0, ok}, {62'h0, spiCtrlPkg::MMIO_READY});
		end
		req.op = spiCtrlPkg::MMIO_IDLE;
		repeat (2) @(negedge clock);
		readReg(CtrlAddr, r);
		checkValue("control after miss", r, {32'h0, value});
		finishTest("address miss", e0);

		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/spiController_assert.sv
// spi controller protocol assertions
// pin idle levels, lane use, bus answer after idle and chip select stability
`timescale 1ns/10ps
`default_nettype none

module spiControllerAssert
(
	input wire logic                 clock,
	input wire logic                 reset,
	input wire spiCtrlPkg::mmioReq_t req,
	input wire spiCtrlPkg::mmioOk_t  ok,
	input wire spiCtrlPkg::spiPins_t pins,
	input wire logic                 busy,
	input wire spiCtrlPkg::spiCtrl_t ctrl
);

	// sclk rests at polarity
	sclkIdle: assert property (@(posedge clock) disable iff (reset)
		!busy |-> (pins.sclk == ctrl.polarity))
		else $error("sclk away from polarity while idle");

	// single lane leaves upper lanes low
	laneUnused: assert property (@(posedge clock) disable iff (reset)
		!ctrl.laneQuad |-> (pins.mosi[3:1] == 3'b000))
		else $error("upper mosi lanes driven in single mode");

	// request and answer are each registered once
	noOkAfterIdle: assert property (@(posedge clock) disable iff (reset)
		(req.op == spiCtrlPkg::MMIO_IDLE) |-> ##2 (ok != spiCtrlPkg::MMIO_OK))
		else $error("OK answer for an idle request");

	csStable: assert property (@(posedge clock) disable iff (reset)
		busy |=> $stable(pins.cs))
		else $error("cs changed during an exchange");

endmodule

bind spiController spiControllerAssert checks
(
	.clock(clock), .reset(reset), .req(req), .ok(ok),
	.pins(pins), .busy(busy), .ctrl(ctrl)
);

`default_nettype wire

//--- verilog/spiBurstQueue.sv
// spi burst queue
// four 64-bit send words fed out low byte first, four receive words filled
// from the top, and the burst byte counter
`timescale 1ns/10ps
`default_nettype none
`include "spiCtrl_consts.svh"

module spiBurstQueue
(
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        queueWrite,
	input  wire logic [1:0]  queueIndex,
	input  wire logic [63:0] queueData,
	input  wire logic        startBurst,
	input  wire logic        burstLong,
	input  wire logic        byteDone,
	input  wire logic [7:0]  rxByte,
	output logic             startByte,
	output logic [7:0]       txByte,
	output logic             pending,
	output logic [63:0]      recvWord0,
	output logic [63:0]      recvWord1,
	output logic [63:0]      recvWord2,
	output logic [63:0]      recvWord3
);

	logic [63:0] sendWord [0:3];
	// bytes left in the burst
	logic [5:0]  byteCount;
	// 32-byte burst fills all four receive words
	logic        longBurst;
	logic        lastByte;
	logic        issueByte;
	logic        takeByte;

	assign pending   = (byteCount != 6'd0);
	assign lastByte  = (byteCount == 6'd1);
	// byteDone from single exchanges is ignored
	assign takeByte  = pending && byteDone;
	// first byte right after start, then one after each byteDone but the last
	assign issueByte = startBurst || (takeByte && !lastByte);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			byteCount <= 6'd0;
			longBurst <= 1'b0;
			startByte <= 1'b0;
		end
		else
		begin
			startByte <= issueByte;
			if (startBurst)
			begin
				byteCount <= burstLong ? `SPI_BURST_LONG : `SPI_BURST_SHORT;
				longBurst <= burstLong;
			end
			else if (takeByte)
				byteCount <= byteCount - 6'd1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (issueByte)
		begin
			txByte <= sendWord[0][7:0];
			// whole chain moves down a byte, 0xFF in at the top
			for (int i = 0; i < 3; i++)
				sendWord[i] <= {sendWord[i+1][7:0], sendWord[i][63:8]};
			sendWord[3] <= {8'hFF, sendWord[3][63:8]};
		end
		// bus write wins over the rotation
		if (queueWrite)
			sendWord[queueIndex] <= queueData;
	end

	always_ff @(posedge clock)
	begin
		if (takeByte)
		begin
			if (longBurst)
			begin
				// byte k ends in byte k of word k div 8
				recvWord3 <= {rxByte, recvWord3[63:8]};
				recvWord2 <= {recvWord3[7:0], recvWord2[63:8]};
				recvWord1 <= {recvWord2[7:0], recvWord1[63:8]};
				recvWord0 <= {recvWord1[7:0], recvWord0[63:8]};
			end
			else
				// short burst only touches word 0
				recvWord0 <= {rxByte, recvWord0[63:8]};
		end
	end

endmodule

`default_nettype wire

//--- verilog/spiClockDivider.sv
// spi clock divider
// counts the half period from divisor and scale, pulses halfTick at its end
`timescale 1ns/10ps
`default_nettype none
`include "spiCtrl_consts.svh"

module spiClockDivider
(
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire spiCtrlPkg::spiCtrl_t ctrl,
	input  wire logic                 run,
	output logic                      halfTick
);

	localparam int unsigned DivWidth = `SPI_DIV_WIDTH;

	// half period in clocks
	logic [DivWidth-1:0] halfPeriod;
	// down counter, tick at zero
	logic [DivWidth-1:0] count;

	always_comb
	begin
		// divisor shifted left by twice the scale
		if (ctrl.divisor == 8'd0)
			halfPeriod = `SPI_DEFAULT_HALF;
		else
			halfPeriod = {{(DivWidth-8){1'b0}}, ctrl.divisor} << {ctrl.scale, 1'b0};
	end

	// largest value 255 << 6 still fits in 14 bits
	assign halfTick = run && (count == '0);

	always_ff @(posedge clock)
	begin
		if (reset)
			count <= '0;
		else if (!run || halfTick)
			// held at reload while idle, so the first half is full length
			count <= halfPeriod - 1'b1;
		else
			count <= count - 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/spiController.sv
// spi master controller, top level
// bus port, burst queue, shift engine and clock divider
`timescale 1ns/10ps
`default_nettype none

module spiController
(
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire spiCtrlPkg::mmioReq_t req,
	output spiCtrlPkg::mmioOk_t       ok,
	output logic [63:0]               readData,
	output spiCtrlPkg::spiPins_t      pins,
	input  wire logic [3:0]           miso
);

	spiCtrlPkg::spiCtrl_t ctrl;
	logic        portStart;
	logic [7:0]  portTx;
	logic        queueStart;
	logic [7:0]  queueTx;
	logic        startByte;
	logic [7:0]  txByte;
	logic        queueWrite;
	logic [1:0]  queueIndex;
	logic [63:0] queueData;
	logic        startBurst;
	logic        burstLong;
	logic        busy;
	logic        pending;
	logic        byteDone;
	logic [7:0]  rxByte;
	logic [63:0] recvWord0;
	logic [63:0] recvWord1;
	logic [63:0] recvWord2;
	logic [63:0] recvWord3;
	logic        run;
	logic        halfTick;

	// port and queue never start a byte in the same cycle
	assign startByte = portStart | queueStart;
	assign txByte    = queueStart ? queueTx : portTx;

	spiMmioPort mmioPort
	(
		.clock(clock), .reset(reset), .req(req), .ok(ok), .readData(readData),
		.ctrl(ctrl), .startByte(portStart), .txByte(portTx),
		.queueWrite(queueWrite), .queueIndex(queueIndex), .queueData(queueData),
		.startBurst(startBurst), .burstLong(burstLong),
		.busy(busy), .pending(pending), .rxByte(rxByte),
		.recvWord0(recvWord0), .recvWord1(recvWord1),
		.recvWord2(recvWord2), .recvWord3(recvWord3)
	);

	spiBurstQueue burstQueue
	(
		.clock(clock), .reset(reset),
		.queueWrite(queueWrite), .queueIndex(queueIndex), .queueData(queueData),
		.startBurst(startBurst), .burstLong(burstLong),
		.byteDone(byteDone), .rxByte(rxByte),
		.startByte(queueStart), .txByte(queueTx), .pending(pending),
		.recvWord0(recvWord0), .recvWord1(recvWord1),
		.recvWord2(recvWord2), .recvWord3(recvWord3)
	);

	spiShifter shifter
	(
		.clock(clock), .reset(reset), .ctrl(ctrl),
		.startByte(startByte), .txByte(txByte), .halfTick(halfTick), .miso(miso),
		.run(run), .busy(busy), .byteDone(byteDone), .rxByte(rxByte), .pins(pins)
	);

	spiClockDivider clockDivider
	(
		.clock(clock), .reset(reset), .ctrl(ctrl), .run(run), .halfTick(halfTick)
	);

endmodule

`default_nettype wire

//--- verilog/spiCtrlPkg.sv
// spi controller shared types
// bus request and answer, shifter states, control register and pin bundle
`default_nettype none

package spiCtrlPkg;

	// bus opcode, held as a level by the requester
	typedef enum logic [1:0]
	{
		MMIO_IDLE  = 2'b00,
		MMIO_READ  = 2'b01,
		MMIO_WRITE = 2'b10
	} mmioOp_t;

	// bus answer
	typedef enum logic [1:0]
	{
		MMIO_READY = 2'b00,
		MMIO_OK    = 2'b01,
		MMIO_HOLD  = 2'b10
	} mmioOk_t;

	// one sclk period is a leading and a trailing half
	typedef enum logic [1:0]
	{
		SHIFT_IDLE  = 2'b00,
		SHIFT_LEAD  = 2'b01,
		SHIFT_TRAIL = 2'b10
	} shiftState_t;

	typedef struct packed
	{
		mmioOp_t     op;
		logic [31:0] addr;
		logic [63:0] data;
	} mmioReq_t;

	// control register, msb first
	typedef struct packed
	{
		logic [7:0] divisor;
		logic [1:0] scale;
		logic [7:0] rsvdHigh;
		logic       polarity;
		logic [2:0] rsvdMid;
		logic       laneQuad;
		logic [1:0] rsvdLane;
		logic       burst32;
		logic       burst8;
		logic [2:0] rsvdLow;
		logic       single;
		logic       chipSelect;
	} spiCtrl_t;

	typedef struct packed
	{
		logic       sclk;
		logic [3:0] mosi;
		logic       cs;
		logic [1:0] laneMode;
	} spiPins_t;

endpackage

`default_nettype wire

//--- verilog/spiCtrl_consts.svh
// spi controller constants
// register map, control bits, divider defaults and burst sizes
`ifndef SPI_CTRL_CONSTS_SVH
`define SPI_CTRL_CONSTS_SVH

// block base address, aligned to its 64-byte window
`define SPI_BASE_ADDR		32'hF000_E040

// register offsets inside the window
`define SPI_REG_CTRL		6'h00
`define SPI_REG_DATA		6'h08
// queue words sit at 0x20, 0x28, 0x30 and 0x38
`define SPI_REG_QUEUE		6'h20

// control read shows busy in this bit
`define SPI_CTRL_BUSY_BIT	1
// start bits single, burst8 and burst32, never stored
`define SPI_CTRL_START_MASK	32'h0000_0062

// divider counter width
`define SPI_DIV_WIDTH		14
// half period used when the divisor field is zero
`define SPI_DEFAULT_HALF	14'd5

// burst lengths in bytes
`define SPI_BURST_SHORT		6'd8
`define SPI_BURST_LONG		6'd32

`endif

//--- verilog/spiMmioPort.sv
// spi bus front end
// registers the level request, decodes the block window, holds the control
// register and forms the registered READY / OK / HOLD answer
`timescale 1ns/10ps
`default_nettype none
`include "spiCtrl_consts.svh"

module spiMmioPort
(
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire spiCtrlPkg::mmioReq_t req,
	output spiCtrlPkg::mmioOk_t       ok,
	output logic [63:0]               readData,
	output spiCtrlPkg::spiCtrl_t      ctrl,
	output logic                      startByte,
	output logic [7:0]                txByte,
	output logic                      queueWrite,
	output logic [1:0]                queueIndex,
	output logic [63:0]               queueData,
	output logic                      startBurst,
	output logic                      burstLong,
	input  wire logic                 busy,
	input  wire logic                 pending,
	input  wire logic [7:0]           rxByte,
	input  wire logic [63:0]          recvWord0,
	input  wire logic [63:0]          recvWord1,
	input  wire logic [63:0]          recvWord2,
	input  wire logic [63:0]          recvWord3
);

	localparam logic [31:0] BaseAddr = `SPI_BASE_ADDR;

	spiCtrlPkg::mmioReq_t reqReg;
	spiCtrlPkg::mmioOk_t  okNext;
	spiCtrlPkg::spiCtrl_t wrCtrl;
	logic [63:0] readNext;
	logic [31:0] ctrlWord;
	logic [5:0]  offset;
	logic        inBlock;
	logic        isCtrl;
	logic        isData;
	logic        isQueue;
	logic        anyBusy;
	// write already carried out, request still held
	logic        writeDone;
	logic        doCtrl;
	logic        doData;
	logic        doQueue;

	assign offset  = reqReg.addr[5:0];
	assign inBlock = (reqReg.addr[31:6] == BaseAddr[31:6]);
	assign isCtrl  = inBlock && ({offset[5:3], 3'b000} == `SPI_REG_CTRL);
	assign isData  = inBlock && ({offset[5:3], 3'b000} == `SPI_REG_DATA);
	assign isQueue = inBlock && ({offset[5], 5'b00000} == `SPI_REG_QUEUE);
	assign anyBusy = busy || pending;
	assign wrCtrl  = reqReg.data[31:0];

	always_comb
	begin
		ctrlWord = ctrl;
		ctrlWord[`SPI_CTRL_BUSY_BIT] = anyBusy;
	end

	always_comb
	begin
		okNext   = spiCtrlPkg::MMIO_READY;
		readNext = 64'h0;
		doCtrl   = 1'b0;
		doData   = 1'b0;
		doQueue  = 1'b0;
		// misses and idle ops stay READY
		if (isCtrl || isData || isQueue)
		begin
			if (reqReg.op == spiCtrlPkg::MMIO_READ)
			begin
				okNext = spiCtrlPkg::MMIO_OK;
				if (isCtrl)
					readNext = {32'h0, ctrlWord};
				else if (isData)
				begin
					readNext = {56'h0, rxByte};
					if (anyBusy)
						okNext = spiCtrlPkg::MMIO_HOLD;
				end
				else
				begin
					case (offset[4:3])
						2'd0: readNext = recvWord0;
						2'd1: readNext = recvWord1;
						2'd2: readNext = recvWord2;
						default: readNext = recvWord3;
					endcase
				end
			end
			else if (reqReg.op == spiCtrlPkg::MMIO_WRITE)
			begin
				okNext = spiCtrlPkg::MMIO_OK;
				if (writeDone)
					okNext = spiCtrlPkg::MMIO_OK;
				else if (isQueue)
					doQueue = 1'b1;
				else if (anyBusy)
					// ctrl and data wait for shifter and burst to finish
					okNext = spiCtrlPkg::MMIO_HOLD;
				else
				begin
					doCtrl = isCtrl;
					doData = isData;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqReg     <= '0;
			ok         <= spiCtrlPkg::MMIO_READY;
			writeDone  <= 1'b0;
			ctrl       <= '0;
			startByte  <= 1'b0;
			startBurst <= 1'b0;
			queueWrite <= 1'b0;
		end
		else
		begin
			reqReg     <= req;
			ok         <= okNext;
			// cleared by the idle cycle between requests
			writeDone  <= (reqReg.op == spiCtrlPkg::MMIO_WRITE)
				&& (writeDone || doCtrl || doData || doQueue);
			// single start wins over the burst starts
			startByte  <= doCtrl && wrCtrl.single;
			startBurst <= doCtrl && !wrCtrl.single && (wrCtrl.burst8 || wrCtrl.burst32);
			queueWrite <= doQueue;
			if (doCtrl)
				ctrl <= reqReg.data[31:0] & ~`SPI_CTRL_START_MASK;
		end
	end

	always_ff @(posedge clock)
	begin
		readData <= readNext;
		if (doData)
			txByte <= reqReg.data[7:0];
		if (doQueue)
		begin
			queueIndex <= offset[4:3];
			queueData  <= reqReg.data;
		end
		if (doCtrl)
			burstLong <= wrCtrl.burst32 && !wrCtrl.burst8;
	end

endmodule

`default_nettype wire

//--- verilog/spiShifter.sv
// spi shift engine
// sends one byte on mosi and takes one from miso, one lane or four lanes
// sclk active in the leading half, miso sampled at its end
`timescale 1ns/10ps
`default_nettype none

module spiShifter
(
	input  wire logic                 clock,
	input  wire logic                 reset,
	input  wire spiCtrlPkg::spiCtrl_t ctrl,
	input  wire logic                 startByte,
	input  wire logic [7:0]           txByte,
	input  wire logic                 halfTick,
	input  wire logic [3:0]           miso,
	output logic                      run,
	output logic                      busy,
	output logic                      byteDone,
	output logic [7:0]                rxByte,
	output spiCtrlPkg::spiPins_t      pins
);

	spiCtrlPkg::shiftState_t state;
	// bits still to send
	logic [3:0] bitCount;
	// one bit or one nibble per period
	logic [3:0] bitStep;
	logic [7:0] txShift;
	logic       lastBits;

	assign bitStep  = ctrl.laneQuad ? 4'd4 : 4'd1;
	assign lastBits = (bitCount == bitStep);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state    <= spiCtrlPkg::SHIFT_IDLE;
			bitCount <= 4'd0;
			byteDone <= 1'b0;
		end
		else
		begin
			byteDone <= 1'b0;
			case (state)
				spiCtrlPkg::SHIFT_IDLE:
				begin
					if (startByte)
					begin
						state    <= spiCtrlPkg::SHIFT_LEAD;
						bitCount <= 4'd8;
					end
				end
				spiCtrlPkg::SHIFT_LEAD:
				begin
					if (halfTick)
						state <= spiCtrlPkg::SHIFT_TRAIL;
				end
				spiCtrlPkg::SHIFT_TRAIL:
				begin
					if (halfTick)
					begin
						bitCount <= bitCount - bitStep;
						// done one clock after the last trailing half
						if (lastBits)
						begin
							state    <= spiCtrlPkg::SHIFT_IDLE;
							byteDone <= 1'b1;
						end
						else
							state <= spiCtrlPkg::SHIFT_LEAD;
					end
				end
				default:
					state <= spiCtrlPkg::SHIFT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		// msb or top nibble first, next bits move up at the trailing end
		if ((state == spiCtrlPkg::SHIFT_IDLE) && startByte)
			txShift <= txByte;
		else if ((state == spiCtrlPkg::SHIFT_TRAIL) && halfTick)
			txShift <= ctrl.laneQuad ? {txShift[3:0], 4'h0} : {txShift[6:0], 1'b0};
		// sample miso as the leading half ends
		if ((state == spiCtrlPkg::SHIFT_LEAD) && halfTick)
			rxByte <= ctrl.laneQuad ? {rxByte[3:0], miso} : {rxByte[6:0], miso[0]};
	end

	assign run  = (state != spiCtrlPkg::SHIFT_IDLE);
	assign busy = run;

	always_comb
	begin
		// sclk rests at polarity
		pins.sclk     = (state == spiCtrlPkg::SHIFT_LEAD) ? ~ctrl.polarity : ctrl.polarity;
		// upper lanes stay low in single mode, all lanes low while idle
		if (!run)
			pins.mosi = 4'h0;
		else if (ctrl.laneQuad)
			pins.mosi = txShift[7:4];
		else
			pins.mosi = {3'b000, txShift[7]};
		pins.cs       = ctrl.chipSelect;
		pins.laneMode = {ctrl.laneQuad, 1'b0};
	end

endmodule

`default_nettype wire
